// ==== include/vlane_defines.svh ====
`ifndef VLANE_DEFINES_SVH
`define VLANE_DEFINES_SVH

// Lane organisation
`define VLANE_NUM       8
`define VLANE_IDX_W     3

// Storage of one vector register inside a lane
`define VREG_LOC_NUM    8
`define LOC_W           3
`define VREG_W          6
`define ADDR_W          9

// Up to 1024 elements per instruction
`define VL_W            11

// Beat index and instruction delay
`define CNT_W           8

// vs1, vs2, vs3
`define OPND_NUM        3
`define BYTES_PER_WORD  4

`endif

// ==== verilog/vlane_pkg.sv ====
`include "vlane_defines.svh"

package vlane_pkg;

    ////////////////////////////////////////////////////////////////////
    // Instruction and element encodings
    ////////////////////////////////////////////////////////////////////
    typedef enum logic {
        INSTR_NORMAL = 1'b0,    // Read, then write after the delay
        INSTR_STORE  = 1'b1     // Read only, data goes to the store unit
    } instr_kind_e;

    typedef logic [1:0] elem_width_t;

    localparam elem_width_t EW_BYTE = 2'd0;
    localparam elem_width_t EW_HALF = 2'd1;
    localparam elem_width_t EW_WORD = 2'd2;   // Code 3 reserved, treated as word

    ////////////////////////////////////////////////////////////////////
    // VRF address, flat for the RAM, split for the counters
    ////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [`VREG_W-1:0] vreg;   // Which vector register
        logic [`LOC_W-1:0]  loc;    // Word inside that register
    } vrf_addr_fields_t;

    typedef union packed {
        logic [`ADDR_W-1:0] flat;
        vrf_addr_fields_t   fld;
    } vrf_addr_u;

endpackage

// ==== verilog/vrf_addr_counter.sv ====
`timescale 1ns/1ps
`include "vlane_defines.svh"

module vrf_addr_counter (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   load_i,
    input  vlane_pkg::vrf_addr_u   start_addr_i,
    input  logic                   step_i,
    input  vlane_pkg::elem_width_t elem_width_i,
    output vlane_pkg::vrf_addr_u   addr_o
);
    import vlane_pkg::*;

    logic [1:0]        sub_q;       // Elements used from current word
    logic [1:0]        sub_last;
    logic              word_done;
    logic [`LOC_W-1:0] loc_next;
    vrf_addr_u         addr_q;

    // Beats per word minus one
    always_comb begin
        case (elem_width_i)
            EW_BYTE: sub_last = 2'd3;
            EW_HALF: sub_last = 2'd1;
            default: sub_last = 2'd0;
        endcase
    end

    assign word_done = (sub_q == sub_last);

    // Stay inside the same vector register
    assign loc_next = (addr_q.fld.loc == `LOC_W'(`VREG_LOC_NUM - 1)) ? '0
                                                                      : addr_q.fld.loc + 1'b1;

    ////////////////////////////////////////////////////////////////////
    // Sub-word counter
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            sub_q <= '0;
        end else if (load_i) begin
            sub_q <= '0;
        end else if (step_i) begin
            sub_q <= word_done ? 2'd0 : sub_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Address register
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            addr_q <= start_addr_i;
        end else if (step_i && word_done) begin
            addr_q.fld.loc <= loc_next;     // vreg is left alone
        end
    end

    assign addr_o = addr_q;

endmodule

// ==== verilog/vlane_seq_ctrl.sv ====
`timescale 1ns/1ps
`include "vlane_defines.svh"

module vlane_seq_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  vlane_pkg::instr_kind_e instr_kind_i,
    input  logic [`VL_W-1:0]       vl_i,
    input  vlane_pkg::elem_width_t elem_width_i,
    input  logic [`CNT_W-1:0]      inst_delay_i,
    output logic                   ready_o,
    output logic                   rd_load_o,
    output logic                   rd_step_o,
    output logic                   wr_step_o,
    output logic                   vrf_ren_o,
    output logic                   vrf_wen_o,
    output logic                   store_valid_o,
    output logic [`CNT_W-1:0]      rd_beat_o,
    output logic [`CNT_W-1:0]      wr_beat_o,
    output logic [`VL_W-1:0]       vl_o,
    output vlane_pkg::elem_width_t elem_width_o
);
    import vlane_pkg::*;

    // Latched instruction
    instr_kind_e       kind_q;
    logic [`VL_W-1:0]  vl_q;
    elem_width_t       ew_q;
    logic [`CNT_W-1:0] delay_q;
    logic [`CNT_W-1:0] n_beats_q;

    // Phase control
    logic              rd_active_q;
    logic              wr_active_q;
    logic [`CNT_W-1:0] rd_cnt_q;
    logic [`CNT_W-1:0] wr_cnt_q;
    logic [`CNT_W-1:0] dly_cnt_q;

    logic              accept;
    logic [`CNT_W-1:0] n_beats;
    logic              rd_last;
    logic              wr_last;
    logic              dly_run;
    logic              wr_start;
    logic              instr_done;

    assign accept = start_i & ready_o;

    // vl / lanes, rounded up
    assign n_beats = `CNT_W'(vl_i >> `VLANE_IDX_W)
                   + `CNT_W'(vl_i[`VLANE_IDX_W-1:0] != '0);

    assign rd_last = rd_active_q && (rd_cnt_q == n_beats_q - 1'b1);
    assign wr_last = wr_active_q && (wr_cnt_q == n_beats_q - 1'b1);

    // Delay count only matters for arithmetic instructions
    assign dly_run  = !ready_o && (kind_q == INSTR_NORMAL) && !wr_active_q;
    assign wr_start = dly_run && (dly_cnt_q == delay_q - 1'b1);

    assign instr_done = (kind_q == INSTR_STORE) ? rd_last : wr_last;

    ////////////////////////////////////////////////////////////////////
    // Configuration latch
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            kind_q    <= instr_kind_i;
            vl_q      <= vl_i;
            ew_q      <= elem_width_i;
            delay_q   <= inst_delay_i;
            n_beats_q <= n_beats;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Handshake, beat and delay counters
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ready_o     <= 1'b1;
            rd_active_q <= 1'b0;
            wr_active_q <= 1'b0;
            rd_cnt_q    <= '0;
            wr_cnt_q    <= '0;
            dly_cnt_q   <= '0;
        end else if (accept) begin
            ready_o     <= 1'b0;
            rd_active_q <= 1'b1;        // Beat 0 in the very next cycle
            rd_cnt_q    <= '0;
            wr_cnt_q    <= '0;
            dly_cnt_q   <= '0;
        end else begin
            if (rd_active_q) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
                if (rd_last) begin
                    rd_active_q <= 1'b0;
                end
            end

            if (dly_run) begin
                dly_cnt_q <= dly_cnt_q + 1'b1;
            end

            // Write beat 0 lands exactly delay cycles after read beat 0
            if (wr_start) begin
                wr_active_q <= 1'b1;
            end else if (wr_active_q) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
                if (wr_last) begin
                    wr_active_q <= 1'b0;
                end
            end

            if (instr_done) begin
                ready_o <= 1'b1;
            end
        end
    end

    assign rd_load_o     = accept;
    assign rd_step_o     = rd_active_q;
    assign wr_step_o     = wr_active_q;
    assign vrf_ren_o     = rd_active_q;
    assign vrf_wen_o     = wr_active_q;
    assign store_valid_o = rd_active_q && (kind_q == INSTR_STORE);
    assign rd_beat_o     = rd_cnt_q;
    assign wr_beat_o     = wr_cnt_q;
    assign vl_o          = vl_q;
    assign elem_width_o  = ew_q;

endmodule

// ==== verilog/lane_write_mask.sv ====
`timescale 1ns/1ps
`include "vlane_defines.svh"

module lane_write_mask (
    input  logic [`CNT_W-1:0]      rd_beat_i,
    input  logic [`CNT_W-1:0]      wr_beat_i,
    input  logic [`VL_W-1:0]       vl_i,
    input  vlane_pkg::elem_width_t elem_width_i,
    input  logic                   vrf_ren_i,
    input  logic                   vrf_wen_i,
    output logic [`VLANE_NUM-1:0]  lane_rd_valid_o,
    output logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] vrf_bwen_o
);
    import vlane_pkg::*;

    logic [`VLANE_NUM-1:0]      rd_live;
    logic [`VLANE_NUM-1:0]      wr_live;
    logic [`BYTES_PER_WORD-1:0] byte_pat;

    ////////////////////////////////////////////////////////////////////
    // Live lanes, element index is beat * lanes + lane
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int l = 0; l < `VLANE_NUM; l++) begin
            rd_live[l] = ({rd_beat_i, `VLANE_IDX_W'(l)} < vl_i);
            wr_live[l] = ({wr_beat_i, `VLANE_IDX_W'(l)} < vl_i);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Byte enable pattern, rotates with the write beat
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        case (elem_width_i)
            EW_BYTE: begin
                // One byte per beat, four beats fill a word
                byte_pat = `BYTES_PER_WORD'(1) << wr_beat_i[1:0];
            end
            EW_HALF: begin
                byte_pat = wr_beat_i[0] ? 4'b1100 : 4'b0011;
            end
            EW_WORD: begin
                byte_pat = '1;
            end
            default: begin
                byte_pat = '1;      // Reserved, same as word
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Phase gating
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        lane_rd_valid_o = '0;
        vrf_bwen_o      = '0;

        if (vrf_ren_i) begin
            lane_rd_valid_o = rd_live;
        end

        if (vrf_wen_i) begin
            for (int l = 0; l < `VLANE_NUM; l++) begin
                vrf_bwen_o[l] = wr_live[l] ? byte_pat : '0;     // Dead lanes write nothing
            end
        end
    end

endmodule

// ==== verilog/sublane_driver.sv ====
`timescale 1ns/1ps
`include "vlane_defines.svh"

module sublane_driver (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Instruction handshake
    input  logic                   start_i,
    output logic                   ready_o,
    input  vlane_pkg::instr_kind_e instr_kind_i,
    input  logic [`VL_W-1:0]       vl_i,
    input  vlane_pkg::elem_width_t elem_width_i,
    input  logic [`CNT_W-1:0]      inst_delay_i,
    input  vlane_pkg::vrf_addr_u [`OPND_NUM-1:0] rd_start_addr_i,
    input  vlane_pkg::vrf_addr_u   wr_start_addr_i,

    // VRF read side
    output logic                   vrf_ren_o,
    output logic [`OPND_NUM-1:0][`ADDR_W-1:0] vrf_raddr_o,
    output logic [`VLANE_NUM-1:0]  lane_rd_valid_o,
    output logic                   store_valid_o,

    // VRF write side
    output logic                   vrf_wen_o,
    output logic [`ADDR_W-1:0]     vrf_waddr_o,
    output logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] vrf_bwen_o
);
    import vlane_pkg::*;

    logic                      rd_load;
    logic                      rd_step;
    logic                      wr_step;
    logic [`CNT_W-1:0]         rd_beat;
    logic [`CNT_W-1:0]         wr_beat;
    logic [`VL_W-1:0]          vl_q;
    elem_width_t               ew_q;
    vrf_addr_u [`OPND_NUM-1:0] rd_addr;
    vrf_addr_u                 wr_addr;

    ////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////
    vlane_seq_ctrl u_seq_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .start_i       (start_i),
        .instr_kind_i  (instr_kind_i),
        .vl_i          (vl_i),
        .elem_width_i  (elem_width_i),
        .inst_delay_i  (inst_delay_i),
        .ready_o       (ready_o),
        .rd_load_o     (rd_load),
        .rd_step_o     (rd_step),
        .wr_step_o     (wr_step),
        .vrf_ren_o     (vrf_ren_o),
        .vrf_wen_o     (vrf_wen_o),
        .store_valid_o (store_valid_o),
        .rd_beat_o     (rd_beat),
        .wr_beat_o     (wr_beat),
        .vl_o          (vl_q),
        .elem_width_o  (ew_q)
    );

    ////////////////////////////////////////////////////////////////////
    // Address counters, one per source operand plus the destination
    ////////////////////////////////////////////////////////////////////
    generate
        for (genvar i = 0; i < `OPND_NUM; i++) begin : g_rd_cnt
            vrf_addr_counter u_rd_cnt (
                .clk_i        (clk_i),
                .rst_i        (rst_i),
                .load_i       (rd_load),
                .start_addr_i (rd_start_addr_i[i]),
                .step_i       (rd_step),
                .elem_width_i (ew_q),
                .addr_o       (rd_addr[i])
            );

            assign vrf_raddr_o[i] = rd_addr[i].flat;
        end
    endgenerate

    // Loaded at acceptance too, then idles until the first write beat
    vrf_addr_counter u_wr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (rd_load),
        .start_addr_i (wr_start_addr_i),
        .step_i       (wr_step),
        .elem_width_i (ew_q),
        .addr_o       (wr_addr)
    );

    assign vrf_waddr_o = wr_addr.flat;

    lane_write_mask u_lane_write_mask (
        .rd_beat_i       (rd_beat),
        .wr_beat_i       (wr_beat),
        .vl_i            (vl_q),
        .elem_width_i    (ew_q),
        .vrf_ren_i       (vrf_ren_o),
        .vrf_wen_i       (vrf_wen_o),
        .lane_rd_valid_o (lane_rd_valid_o),
        .vrf_bwen_o      (vrf_bwen_o)
    );

endmodule

// ==== test/tb_sublane_driver.sv ====
`timescale 1ns/1ps
`include "vlane_defines.svh"

module tb_sublane_driver;
    import vlane_pkg::*;

    localparam int TIMEOUT = 2000;  // Cycles per wait loop

    logic                      clk_i;
    logic                      rst_i;
    logic                      start_i;
    instr_kind_e               instr_kind_i;
    logic [`VL_W-1:0]          vl_i;
    elem_width_t               elem_width_i;
    logic [`CNT_W-1:0]         inst_delay_i;
    vrf_addr_u [`OPND_NUM-1:0] rd_start_addr_i;
    vrf_addr_u                 wr_start_addr_i;
    logic                      ready_o, vrf_ren_o, vrf_wen_o, store_valid_o;
    logic [`OPND_NUM-1:0][`ADDR_W-1:0]          vrf_raddr_o;
    logic [`VLANE_NUM-1:0]                      lane_rd_valid_o;
    logic [`ADDR_W-1:0]                         vrf_waddr_o;
    logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] vrf_bwen_o;

    int  cycle = 0;
    int  checks = 0;
    int  addr_errs = 0, lane_errs = 0, bwen_errs = 0, flag_errs = 0, other_errs = 0;
    int  issued = 0, accepted = 0, finished = 0;
    bit  timed_out = 0;
    bit  active = 0;                // Instruction in flight
    int  acc_cycle = 0, cur_beats = 0, cur_last = 0, cur_dly = 0, cur_vl = 0;
    int  rd_seen = 0, wr_seen = 0;
    instr_kind_e               cur_kind = INSTR_NORMAL;
    elem_width_t               cur_ew = EW_WORD;
    vrf_addr_u [`OPND_NUM-1:0] cur_rd_start;
    vrf_addr_u                 cur_wr_start;

    sublane_driver u_sublane_driver (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // Expected values
    //////////////////////////////////////////////////////////////////////
    function automatic int exp_beats(input int vl);
        return (vl + `VLANE_NUM - 1) / `VLANE_NUM;
    endfunction

    function automatic logic [`VLANE_NUM-1:0] exp_lanes(input int vl, input int beat);
        logic [`VLANE_NUM-1:0] live;
        for (int l = 0; l < `VLANE_NUM; l++) live[l] = (beat * `VLANE_NUM + l) < vl;
        return live;
    endfunction

    // loc moves once per filled word and wraps inside the register
    function automatic vrf_addr_u exp_addr(input vrf_addr_u start, input elem_width_t ew,
                                           input int beat);
        vrf_addr_u a;
        int        stride;
        stride = (ew == EW_BYTE) ? 4 : (ew == EW_HALF) ? 2 : 1;
        a = start;
        a.fld.loc = `LOC_W'((int'(start.fld.loc) + beat / stride) % `VREG_LOC_NUM);
        return a;
    endfunction

    function automatic logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] exp_bwen(
        input int vl, input elem_width_t ew, input int beat);
        logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] en;
        logic [`BYTES_PER_WORD-1:0]                 pat;
        logic [`VLANE_NUM-1:0]                      live;
        if (ew == EW_BYTE) pat = 4'b0001 << (beat % 4);
        else if (ew == EW_HALF) pat = (beat % 2) ? 4'b1100 : 4'b0011;
        else pat = 4'b1111;         // Word and reserved code
        live = exp_lanes(vl, beat);
        for (int l = 0; l < `VLANE_NUM; l++) en[l] = live[l] ? pat : '0;
        return en;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_addr(input string name, input vrf_addr_u got, input vrf_addr_u exp);
        checks++;
        if (got !== exp) begin
            addr_errs++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_lanes(input string name, input logic [`VLANE_NUM-1:0] got,
                               input logic [`VLANE_NUM-1:0] exp);
        checks++;
        if (got !== exp) begin
            lane_errs++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bwen(input string name,
                              input logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] got,
                              input logic [`VLANE_NUM-1:0][`BYTES_PER_WORD-1:0] exp);
        checks++;
        if (got !== exp) begin
            bwen_errs++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            flag_errs++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            other_errs++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        other_errs++;
        timed_out = 1'b1;
        $display("Timeout after %0d cycles: %s", TIMEOUT, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor samples outputs mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin : monitor
        int   t;
        logic e_ren, e_wen, e_rdy;
        if (rst_i) begin
            t     = cycle - acc_cycle;  // Read beat index
            e_ren = active && t < cur_beats;
            e_wen = active && cur_kind == INSTR_NORMAL && t >= cur_dly
                    && t < cur_dly + cur_beats;
            e_rdy = !active || t > cur_last;
            check_flag("ready_o", ready_o, e_rdy);
            check_flag("vrf_ren_o", vrf_ren_o, e_ren);
            check_flag("vrf_wen_o", vrf_wen_o, e_wen);
            check_flag("store_valid_o", store_valid_o, e_ren && cur_kind == INSTR_STORE);
            if (e_ren) begin
                for (int i = 0; i < `OPND_NUM; i++) begin
                    check_addr($sformatf("vrf_raddr_o[%0d]", i), vrf_raddr_o[i],
                               exp_addr(cur_rd_start[i], cur_ew, t));
                end
            end
            if (e_wen) check_addr("vrf_waddr_o", vrf_waddr_o,
                                  exp_addr(cur_wr_start, cur_ew, t - cur_dly));
            check_lanes("lane_rd_valid_o", lane_rd_valid_o, e_ren ? exp_lanes(cur_vl, t) : '0);
            check_bwen("vrf_bwen_o", vrf_bwen_o,
                       e_wen ? exp_bwen(cur_vl, cur_ew, t - cur_dly) : '0);
            if (vrf_ren_o === 1'b1) rd_seen++;
            if (vrf_wen_o === 1'b1) wr_seen++;
            if (active && e_rdy) begin
                check_count("read beats", rd_seen, cur_beats);
                check_count("write beats", wr_seen,
                            cur_kind == INSTR_NORMAL ? cur_beats : 0);
                if (ready_o === 1'b1) finished++;   // DUT back in idle on time
                active = 1'b0;
            end
            // Acceptance happens at the coming edge
            if (!active && start_i === 1'b1) begin
                cur_kind     = instr_kind_i;
                cur_vl       = vl_i;
                cur_ew       = elem_width_i;
                cur_dly      = inst_delay_i;
                cur_rd_start = rd_start_addr_i;
                cur_wr_start = wr_start_addr_i;
                cur_beats    = exp_beats(vl_i);
                cur_last     = cur_beats - 1 + (instr_kind_i == INSTR_NORMAL ? cur_dly : 0);
                acc_cycle    = cycle + 1;
                rd_seen      = 0;
                wr_seen      = 0;
                accepted++;
                active = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    // hold keeps start_i high so the next call queues behind this one
    task automatic run_instr(input instr_kind_e kind, input int vl, input elem_width_t ew,
                             input int dly, input bit wrap, input bit hold);
        int        waited;
        vrf_addr_u a;
        if (timed_out) return;
        instr_kind_i = kind;
        vl_i         = `VL_W'(vl);
        elem_width_i = ew;
        inst_delay_i = `CNT_W'(dly);
        for (int i = 0; i <= `OPND_NUM; i++) begin
            a.flat = `ADDR_W'($urandom);
            if (wrap) a.fld.loc = '1;
            if (i < `OPND_NUM) rd_start_addr_i[i] = a;
            else wr_start_addr_i = a;
        end
        start_i = 1'b1;
        waited  = 0;
        while (!ready_o && !timed_out) begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > TIMEOUT) report_timeout("instruction was never accepted");
        end
        if (timed_out) return;
        @(posedge clk_i);
        #1;
        issued++;
        if (hold) return;
        start_i = 1'b0;
        waited  = 0;
        while (!ready_o && !timed_out) begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > TIMEOUT) report_timeout("ready_o did not return after the instruction");
        end
    endtask

    initial begin
        int waited;
        void'($urandom(32'h916ee51d));
        rst_i           = 1'b0;
        start_i         = 1'b0;
        instr_kind_i    = INSTR_NORMAL;
        vl_i            = '0;
        elem_width_i    = EW_WORD;
        inst_delay_i    = 8'd1;
        rd_start_addr_i = '0;
        wr_start_addr_i = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        repeat (3) @(posedge clk_i);    // Idle state after reset
        #1;

        for (int n = 0; n < 6; n++) begin
            run_instr(INSTR_NORMAL, $urandom_range(300, 1), elem_width_t'($urandom_range(3, 0)),
                      $urandom_range(8, 1), 1'b0, 1'b0);
        end
        run_instr(INSTR_NORMAL, 8, EW_WORD, 1, 1'b0, 1'b0);
        run_instr(INSTR_NORMAL, 13, EW_HALF, 2, 1'b0, 1'b0);
        for (int n = 0; n < 2; n++) begin
            run_instr(INSTR_STORE, $urandom_range(300, 1), elem_width_t'($urandom_range(3, 0)),
                      $urandom_range(8, 1), 1'b0, 1'b0);
        end
        // loc starts at 7 and wraps several times
        run_instr(INSTR_NORMAL, 256, EW_BYTE, 3, 1'b1, 1'b0);
        run_instr(INSTR_STORE, 1024, EW_BYTE, 1, 1'b1, 1'b0);
        for (int n = 0; n < 4; n++) begin
            run_instr($urandom_range(1, 0) ? INSTR_STORE : INSTR_NORMAL, $urandom_range(100, 1),
                      elem_width_t'($urandom_range(3, 0)), $urandom_range(8, 1), 1'b0, n < 3);
        end

        waited = 0;
        while ((active || ready_o !== 1'b1) && !timed_out) begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > TIMEOUT) report_timeout("DUT did not return to idle");
        end
        repeat (2) @(posedge clk_i);
        check_count("accepted instructions", accepted, issued);
        check_count("finished instructions", finished, issued);

        $display("%0d checks, errors: addr %0d lanes %0d bwen %0d flag %0d other %0d",
                 checks, addr_errs, lane_errs, bwen_errs, flag_errs, other_errs);
        if (addr_errs + lane_errs + bwen_errs + flag_errs + other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
verilog/vlane_pkg.sv
verilog/vrf_addr_counter.sv
verilog/vlane_seq_ctrl.sv
verilog/lane_write_mask.sv
verilog/sublane_driver.sv
test/tb_sublane_driver.sv

// ==== Bender.yml ====
package:
  name: sublane_driver

export_include_dirs:
  - include

sources:
  - files:
      - verilog/vlane_pkg.sv
      - verilog/vrf_addr_counter.sv
      - verilog/vlane_seq_ctrl.sv
      - verilog/lane_write_mask.sv
      - verilog/sublane_driver.sv
  - target: test
    files:
      - test/tb_sublane_driver.sv
